// ==== common/super6502_pkg.sv ====
`default_nettype none

package super6502_pkg;

    localparam int DATA_W  = 8;
    localparam int ADDR_W  = 16;
    localparam int NUM_IRQ = 8;

    // Peripheral window bases
    localparam logic [ADDR_W-1:0] LEDS_ADDR  = 16'h7FF0;
    localparam logic [ADDR_W-1:0] TIMER_BASE = 16'h7FF4;  // 4 regs
    localparam logic [ADDR_W-1:0] MULT_BASE  = 16'h7FE8;  // 8 regs
    localparam logic [ADDR_W-1:0] IRQ_BASE   = 16'h7FF8;  // 2 regs

    typedef enum logic [1:0] {
        TMR_LO   = 2'd0,  // Reload low / count low
        TMR_HI   = 2'd1,  // Reload high / count high
        TMR_CTRL = 2'd2,  // Enable, irq enable
        TMR_STAT = 2'd3   // Expired, write 1 to clear
    } timer_reg_e;

    typedef enum logic [2:0] {
        A_LO = 3'd0,
        A_HI = 3'd1,
        B_LO = 3'd2,
        B_HI = 3'd3,
        P0   = 3'd4,  // Product bytes, read only
        P1   = 3'd5,
        P2   = 3'd6,
        P3   = 3'd7
    } mult_reg_e;

    typedef enum logic {
        IRQ_EN   = 1'b0,
        IRQ_STAT = 1'b1
    } irq_reg_e;

endpackage

`default_nettype wire

// ==== hdl/addr_decode.sv ====
`default_nettype none

module addr_decode (
    input  wire logic [super6502_pkg::ADDR_W-1:0] i_addr,
    output logic                                  o_leds_cs,
    output logic                                  o_timer_cs,
    output logic                                  o_mult_cs,
    output logic                                  o_irq_cs
);

    always_comb begin
        o_leds_cs  = (i_addr == super6502_pkg::LEDS_ADDR);
        o_timer_cs = (i_addr[15:2] == super6502_pkg::TIMER_BASE[15:2]);
        o_mult_cs  = (i_addr[15:3] == super6502_pkg::MULT_BASE[15:3]);
        o_irq_cs   = (i_addr[15:1] == super6502_pkg::IRQ_BASE[15:1]);
    end

    // The read mux in the top relies on the windows never overlapping
    always_comb begin
        a_single_cs : assert final ($onehot0({o_leds_cs, o_timer_cs, o_mult_cs, o_irq_cs}))
            else $error("addr_decode: overlapping chip selects at %h", i_addr);
    end

endmodule

`default_nettype wire

// ==== hdl/leds.sv ====
`default_nettype none

module leds (
    input  wire logic                                clk_2,
    input  wire logic                                i_rst_n,
    input  wire logic                                i_cs,
    input  wire logic                                i_rwb,
    input  wire logic [super6502_pkg::DATA_W-1:0]    i_data,
    output logic      [super6502_pkg::DATA_W-1:0]    o_data,
    output logic      [super6502_pkg::DATA_W-1:0]    o_leds
);

    logic [super6502_pkg::DATA_W-1:0] led_q;

    always_ff @(posedge clk_2 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            led_q <= '0;
        end else if (i_cs && !i_rwb) begin
            led_q <= i_data;
        end
    end

    assign o_data = led_q;  // Readback
    assign o_leds = led_q;

endmodule

`default_nettype wire

// ==== timer/timer.sv ====
`default_nettype none

module timer (
    input  wire logic                                clk_2,
    input  wire logic                                i_rst_n,
    input  wire logic                                i_cs,
    input  wire logic                                i_rwb,
    input  wire logic [1:0]                          i_addr,
    input  wire logic [super6502_pkg::DATA_W-1:0]    i_data,
    output logic      [super6502_pkg::DATA_W-1:0]    o_data,
    output logic                                     o_irqb
);

    super6502_pkg::timer_reg_e reg_sel;

    logic [15:0] reload;
    logic [15:0] count;
    logic        enable;
    logic        irq_en;
    logic        expired;
    logic        wr;

    assign reg_sel = super6502_pkg::timer_reg_e'(i_addr);
    assign wr      = i_cs && !i_rwb;

    always_ff @(posedge clk_2 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reload  <= '0;
            count   <= '0;
            enable  <= 1'b0;
            irq_en  <= 1'b0;
            expired <= 1'b0;
        end else begin
            if (wr && reg_sel == super6502_pkg::TMR_LO) reload[7:0] <= i_data;
            if (wr && reg_sel == super6502_pkg::TMR_HI) reload[15:8] <= i_data;
            if (wr && reg_sel == super6502_pkg::TMR_CTRL) begin
                enable <= i_data[0];
                irq_en <= i_data[1];
            end
            if (wr && reg_sel == super6502_pkg::TMR_STAT && i_data[0]) begin
                expired <= 1'b0;
            end

            // High byte write restarts the count with the new reload
            if (wr && reg_sel == super6502_pkg::TMR_HI) begin
                count <= {i_data, reload[7:0]};
            end else if (enable) begin
                if (count == 16'd0) begin
                    count   <= reload;
                    expired <= 1'b1;  // Set wins over a same-cycle clear
                end else begin
                    count <= count - 16'd1;
                end
            end
        end
    end

    always_comb begin
        unique case (reg_sel)
            super6502_pkg::TMR_LO:   o_data = count[7:0];
            super6502_pkg::TMR_HI:   o_data = count[15:8];
            super6502_pkg::TMR_CTRL: o_data = {6'd0, irq_en, enable};
            super6502_pkg::TMR_STAT: o_data = {7'd0, expired};
            default:                 o_data = '0;
        endcase
    end

    assign o_irqb = ~(expired & irq_en);

    // A new interrupt needs an expiry, either now or already standing
    a_irq_source : assert property (@(posedge clk_2) disable iff (!i_rst_n)
        $fell(o_irqb) |-> expired && irq_en
                          && ($past(expired) || $past(enable && count == 16'd0)))
        else $error("timer: interrupt asserted without expiry");

endmodule

`default_nettype wire

// ==== multiplier/multiplier.sv ====
`default_nettype none

module multiplier (
    input  wire logic                                clk_2,
    input  wire logic                                i_rst_n,
    input  wire logic                                i_cs,
    input  wire logic                                i_rwb,
    input  wire logic [2:0]                          i_addr,
    input  wire logic [super6502_pkg::DATA_W-1:0]    i_data,
    output logic      [super6502_pkg::DATA_W-1:0]    o_data
);

    super6502_pkg::mult_reg_e reg_sel;

    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [31:0] product;

    assign reg_sel = super6502_pkg::mult_reg_e'(i_addr);

    always_ff @(posedge clk_2 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (i_cs && !i_rwb) begin
            case (reg_sel)
                super6502_pkg::A_LO: op_a[7:0]  <= i_data;
                super6502_pkg::A_HI: op_a[15:8] <= i_data;
                super6502_pkg::B_LO: op_b[7:0]  <= i_data;
                super6502_pkg::B_HI: op_b[15:8] <= i_data;
                default: ;  // Product bytes are read only
            endcase
        end
    end

    // One register stage, valid the cycle after the last operand write
    always_ff @(posedge clk_2 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            product <= '0;
        end else begin
            product <= op_a * op_b;
        end
    end

    always_comb begin
        unique case (reg_sel)
            super6502_pkg::A_LO: o_data = op_a[7:0];
            super6502_pkg::A_HI: o_data = op_a[15:8];
            super6502_pkg::B_LO: o_data = op_b[7:0];
            super6502_pkg::B_HI: o_data = op_b[15:8];
            super6502_pkg::P0:   o_data = product[7:0];
            super6502_pkg::P1:   o_data = product[15:8];
            super6502_pkg::P2:   o_data = product[23:16];
            super6502_pkg::P3:   o_data = product[31:24];
            default:             o_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/interrupt_controller.sv ====
`default_nettype none

module interrupt_controller (
    input  wire logic                                clk_2,
    input  wire logic                                i_rst_n,
    input  wire logic                                i_cs,
    input  wire logic                                i_rwb,
    input  wire logic                                i_addr,
    input  wire logic [super6502_pkg::DATA_W-1:0]    i_data,
    input  wire logic [super6502_pkg::NUM_IRQ-1:0]   i_irqb,
    output logic      [super6502_pkg::DATA_W-1:0]    o_data,
    output logic                                     o_irqb_master
);

    super6502_pkg::irq_reg_e reg_sel;

    logic [super6502_pkg::NUM_IRQ-1:0] mask;
    logic [super6502_pkg::NUM_IRQ-1:0] pending;

    assign reg_sel = super6502_pkg::irq_reg_e'(i_addr);
    assign pending = ~i_irqb;  // Sources are active low

    always_ff @(posedge clk_2 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mask <= '0;
        end else if (i_cs && !i_rwb && reg_sel == super6502_pkg::IRQ_EN) begin
            mask <= i_data;
        end
    end

    always_comb begin
        unique case (reg_sel)
            super6502_pkg::IRQ_EN:   o_data = mask;
            super6502_pkg::IRQ_STAT: o_data = pending;
            default:                 o_data = '0;
        endcase
    end

    assign o_irqb_master = ~|(pending & mask);

endmodule

`default_nettype wire

// ==== hdl/super6502.sv ====
`default_nettype none

module super6502 (
    input  wire logic                                clk_2,
    input  wire logic                                i_rst_n,
    input  wire logic                                i_cpu_rwb,
    input  wire logic [super6502_pkg::ADDR_W-1:0]    i_cpu_addr,
    input  wire logic [super6502_pkg::DATA_W-1:0]    i_cpu_data_in,
    input  wire logic [super6502_pkg::NUM_IRQ-1:1]   i_ext_irqb,
    output logic      [super6502_pkg::DATA_W-1:0]    o_cpu_data_out,
    output logic      [super6502_pkg::DATA_W-1:0]    o_cpu_data_oe,
    output logic      [super6502_pkg::DATA_W-1:0]    o_leds,
    output logic                                     o_cpu_irqb,
    output logic                                     o_cpu_nmib,
    output logic                                     o_cpu_rdy,
    output logic                                     o_cpu_resb,
    output logic                                     o_cpu_phi2
);

    logic rst_meta;
    logic leds_cs;
    logic timer_cs;
    logic mult_cs;
    logic irq_cs;
    logic timer_irqb;

    logic [super6502_pkg::DATA_W-1:0] leds_rdata;
    logic [super6502_pkg::DATA_W-1:0] timer_rdata;
    logic [super6502_pkg::DATA_W-1:0] mult_rdata;
    logic [super6502_pkg::DATA_W-1:0] irq_rdata;

    assign o_cpu_data_oe = {super6502_pkg::DATA_W{i_cpu_rwb}};
    assign o_cpu_rdy     = 1'b1;
    assign o_cpu_nmib    = 1'b1;
    assign o_cpu_phi2    = clk_2;

    // CPU reset leaves on the second edge after i_rst_n releases
    always_ff @(posedge clk_2 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rst_meta   <= 1'b0;
            o_cpu_resb <= 1'b0;
        end else begin
            rst_meta   <= 1'b1;
            o_cpu_resb <= rst_meta;
        end
    end

    addr_decode u_addr_decode (
        .i_addr     (i_cpu_addr),
        .o_leds_cs  (leds_cs),
        .o_timer_cs (timer_cs),
        .o_mult_cs  (mult_cs),
        .o_irq_cs   (irq_cs)
    );

    always_comb begin
        if (leds_cs)        o_cpu_data_out = leds_rdata;
        else if (timer_cs)  o_cpu_data_out = timer_rdata;
        else if (mult_cs)   o_cpu_data_out = mult_rdata;
        else if (irq_cs)    o_cpu_data_out = irq_rdata;
        else                o_cpu_data_out = '0;  // Unmapped
    end

    leds u_leds (
        .clk_2 (clk_2),          .i_rst_n (i_rst_n),
        .i_cs  (leds_cs),        .i_rwb   (i_cpu_rwb),
        .i_data(i_cpu_data_in),  .o_data  (leds_rdata),
        .o_leds(o_leds)
    );

    timer u_timer (
        .clk_2 (clk_2),          .i_rst_n (i_rst_n),
        .i_cs  (timer_cs),       .i_rwb   (i_cpu_rwb),
        .i_addr(i_cpu_addr[1:0]),
        .i_data(i_cpu_data_in),  .o_data  (timer_rdata),
        .o_irqb(timer_irqb)
    );

    multiplier u_multiplier (
        .clk_2 (clk_2),          .i_rst_n (i_rst_n),
        .i_cs  (mult_cs),        .i_rwb   (i_cpu_rwb),
        .i_addr(i_cpu_addr[2:0]),
        .i_data(i_cpu_data_in),  .o_data  (mult_rdata)
    );

    interrupt_controller u_interrupt_controller (
        .clk_2         (clk_2),
        .i_rst_n       (i_rst_n),
        .i_cs          (irq_cs),
        .i_rwb         (i_cpu_rwb),
        .i_addr        (i_cpu_addr[0]),
        .i_data        (i_cpu_data_in),
        .i_irqb        ({i_ext_irqb, timer_irqb}),  // Timer on line 0
        .o_data        (irq_rdata),
        .o_irqb_master (o_cpu_irqb)
    );

endmodule

`default_nettype wire

// ==== tb/tb_super6502.sv ====
`default_nettype none

module tb_super6502;

    timeunit 1ns;
    timeprecision 100ps;

    localparam string STIM_FILE     = "tb/super6502_stim.txt";
    localparam int    CYCLES_PER_OP = 64;

    logic        clk_2;
    logic        i_rst_n;
    logic        i_cpu_rwb;
    logic [15:0] i_cpu_addr;
    logic [7:0]  i_cpu_data_in;
    logic [7:1]  i_ext_irqb;
    logic [7:0]  o_cpu_data_out;
    logic [7:0]  o_cpu_data_oe;
    logic [7:0]  o_leds;
    logic        o_cpu_irqb;
    logic        o_cpu_nmib;
    logic        o_cpu_rdy;
    logic        o_cpu_resb;
    logic        o_cpu_phi2;

    byte         op_q[$];
    logic [15:0] addr_q[$];
    logic [7:0]  data_q[$];
    logic [7:0]  exp_q[$];
    bit          loaded;
    int          value_errors;
    int          other_errors;
    int          checks;
    logic [15:0] mult_a;  // Shadow operands for the product model
    logic [15:0] mult_b;

    super6502 DUT (.*);

    always #2 clk_2 = ~clk_2;

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("FAIL at %0d ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_problem({"cannot open stimulus file ", STIM_FILE});
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 7 || line[0] == "#") continue;  // Blank or comment
                n = $sscanf(line, "%c %h %h %h", op, addr, data, exp);
                if (n != 4) begin
                    report_problem({"malformed stimulus line: ", line});
                end else begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    exp_q.push_back(exp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_bus(input logic rwb, input logic [15:0] addr, input logic [7:0] data);
        #1;
        i_cpu_rwb     = rwb;
        i_cpu_addr    = addr;
        i_cpu_data_in = data;
    endtask

    // Starts and ends on a rising clk_2 edge
    task automatic run_op(input byte op, input logic [15:0] addr, input logic [7:0] data,
                          input logic [7:0] exp);
        logic [7:0]  want;
        logic [31:0] product;
        want = exp;
        case (op)
            "W": begin
                drive_bus(1'b0, addr, data);
                if (addr[15:3] == super6502_pkg::MULT_BASE[15:3] && !addr[2]) begin
                    case (addr[1:0])
                        2'd0: mult_a[7:0]  = data;
                        2'd1: mult_a[15:8] = data;
                        2'd2: mult_b[7:0]  = data;
                        2'd3: mult_b[15:8] = data;
                    endcase
                end
                @(negedge clk_2);
                check_value("data_oe during write", o_cpu_data_oe, 8'h00);
            end
            "R": begin
                drive_bus(1'b1, addr, 8'h00);
                if (addr[15:3] == super6502_pkg::MULT_BASE[15:3] && addr[2]) begin
                    product = mult_a * mult_b;
                    want    = product[8*addr[1:0] +: 8];
                    if (want !== exp) report_problem("stimulus product byte disagrees with A*B");
                end
                @(negedge clk_2);
                check_value($sformatf("read of %h", addr), o_cpu_data_out, want);
                check_value("data_oe during read", o_cpu_data_oe, 8'hFF);
            end
            "I": begin
                drive_bus(1'b1, 16'h0000, 8'h00);
                i_ext_irqb = data[7:1];
            end
            "Q": begin
                drive_bus(1'b1, 16'h0000, 8'h00);
                @(negedge clk_2);
                check_value("o_cpu_irqb", {7'd0, o_cpu_irqb}, exp);
            end
            "L": begin
                drive_bus(1'b1, 16'h0000, 8'h00);
                @(negedge clk_2);
                check_value("o_leds", o_leds, exp);
            end
            "N": begin
                drive_bus(1'b1, 16'h0000, 8'h00);
                repeat (int'(data) - 1) @(posedge clk_2);
            end
            default: report_problem($sformatf("unknown stimulus opcode %c", op));
        endcase
        @(posedge clk_2);
    endtask

    initial begin
        clk_2         = 1'b0;
        i_rst_n       = 1'b0;
        i_cpu_rwb     = 1'b1;
        i_cpu_addr    = '0;
        i_cpu_data_in = '0;
        i_ext_irqb    = '1;
        value_errors  = 0;
        other_errors  = 0;
        checks        = 0;
        mult_a        = '0;
        mult_b        = '0;
        loaded        = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (5) @(posedge clk_2);
        check_value("o_cpu_resb in reset", {7'd0, o_cpu_resb}, 8'h00);
        #1;
        i_rst_n = 1'b1;
        @(posedge clk_2);
        @(negedge clk_2);
        check_value("o_cpu_resb one edge after release", {7'd0, o_cpu_resb}, 8'h00);
        @(posedge clk_2);
        @(negedge clk_2);
        check_value("o_cpu_resb two edges after release", {7'd0, o_cpu_resb}, 8'h01);
        check_value("o_cpu_nmib", {7'd0, o_cpu_nmib}, 8'h01);
        check_value("o_cpu_rdy", {7'd0, o_cpu_rdy}, 8'h01);
        #1;
        check_value("o_cpu_phi2 in low phase", {7'd0, o_cpu_phi2}, 8'h00);
        @(posedge clk_2);
        #1;
        check_value("o_cpu_phi2 in high phase", {7'd0, o_cpu_phi2}, 8'h01);
        @(posedge clk_2);
        foreach (op_q[i]) begin
            run_op(op_q[i], addr_q[i], data_q[i], exp_q[i]);
        end
        $display("%0d checks, %0d value errors, %0d other errors",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat ((op_q.size() + 16) * CYCLES_PER_OP) @(posedge clk_2);
        $display("timeout: stimulus did not complete within %0d cycles",
                 (op_q.size() + 16) * CYCLES_PER_OP);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/super6502_pkg.sv
hdl/addr_decode.sv
hdl/leds.sv
timer/timer.sv
multiplier/multiplier.sv
hdl/interrupt_controller.sv
hdl/super6502.sv
tb/tb_super6502.sv

// ==== Bender.yml ====
package:
  name: super6502

sources:
  - common/super6502_pkg.sv
  - hdl/addr_decode.sv
  - hdl/leds.sv
  - timer/timer.sv
  - multiplier/multiplier.sv
  - hdl/interrupt_controller.sv
  - hdl/super6502.sv
  - target: test
    files:
      - tb/tb_super6502.sv

// ==== tb/super6502_stim.txt ====
# op addr data expect, all hex. W write, R read, I ext irq lines (data[7:1]),
# Q check o_cpu_irqb, L check o_leds, N wait data cycles
Q 0000 00 01
L 0000 00 00
R 7FF0 00 00
R 1234 00 00
W 7FF0 A5 00
L 0000 00 A5
R 7FF0 00 A5
# Operands A=5504 B=0E4F, first xorshift32 output of seed 419d
W 7FE8 04 00
W 7FE9 55 00
W 7FEA 4F 00
W 7FEB 0E 00
N 0000 01 00
R 7FEC 00 3C
R 7FED 00 74
R 7FEE 00 C0
R 7FEF 00 04
# Timer reload 20, expiry 21 cycles after enable
W 7FF4 14 00
W 7FF5 00 00
W 7FF6 03 00
N 0000 1E 00
R 7FF7 00 01
W 7FF8 01 00
Q 0000 00 00
W 7FF7 01 00
Q 0000 00 01
W 7FF6 00 00
W 7FF8 00 00
I 0000 F7 00
R 7FF9 00 08
Q 0000 00 01
W 7FF8 08 00
Q 0000 00 00
W 7FF8 00 00
Q 0000 00 01
I 0000 FF 00
W 7FF8 08 00
Q 0000 00 01
